// ==== logic/mgmt_pkg.sv ====
`default_nettype none

package mgmt_pkg;

	////////////////////////////////////////
	// Bus and field widths

	// Host register bus
	typedef logic [15:0] reg_addr_t;
	typedef logic [7:0]  reg_data_t;

	// Crossbar selector per trigger channel
	typedef logic [3:0]  muxsel_t;

	// Transceiver DRP port
	typedef logic [8:0]  drp_addr_t;
	typedef logic [15:0] drp_data_t;

	// Trigger channel counts
	localparam int NUM_TRIG  = 12;
	// Relay channels are the top outputs, 8 to 11
	localparam int NUM_RELAY = 4;

	////////////////////////////////////////
	// Register address map

	// Front panel SPI
	localparam reg_addr_t REG_FRONT_CTRL  = 16'h0050;
	localparam reg_addr_t REG_FRONT_DATA  = 16'h0051;
	localparam reg_addr_t REG_FRONT_STAT  = 16'h0052;
	localparam reg_addr_t REG_FRONT_LED_0 = 16'h0053;
	localparam reg_addr_t REG_FRONT_LED_1 = 16'h0054;
	localparam reg_addr_t REG_FRONT_LED_2 = 16'h0055;

	// First of twelve consecutive selector registers
	localparam reg_addr_t REG_MUXSEL_BASE = 16'h00f0;

	// DRP lane windows, 32 bytes each
	localparam reg_addr_t REG_LANE0_BASE  = 16'h0080;
	localparam reg_addr_t REG_LANE1_BASE  = 16'h00a0;

	// Offsets inside a lane window
	localparam logic [7:0] DRP_OFF_WD   = 8'h04;
	localparam logic [7:0] DRP_OFF_WD_1 = 8'h05;
	localparam logic [7:0] DRP_OFF_AD   = 8'h06;
	localparam logic [7:0] DRP_OFF_AD_1 = 8'h07;
	localparam logic [7:0] DRP_OFF_RD   = 8'h08;
	localparam logic [7:0] DRP_OFF_RD_1 = 8'h09;
	localparam logic [7:0] DRP_OFF_STAT = 8'h0a;

endpackage

`default_nettype wire

// ==== logic/trig_mux_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_mux_select (
	input  wire                                        clk,
	input  wire                                        rst_n,

	// Host write port
	input  wire                                        wr_en,
	input  mgmt_pkg::reg_addr_t                        wr_addr,
	input  mgmt_pkg::reg_data_t                        wr_data,

	// One selector per trigger output
	output mgmt_pkg::muxsel_t [mgmt_pkg::NUM_TRIG-1:0] muxsel
);

	import mgmt_pkg::*;

	////////////////////////////////////////
	// Selector bank

	// Channel k lives at REG_MUXSEL_BASE + k
	// Addresses past the last channel match nothing
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			muxsel <= '0;
		end
		else if (wr_en) begin
			for (int k = 0; k < NUM_TRIG; k++) begin
				if (wr_addr == reg_addr_t'(REG_MUXSEL_BASE + k))
					muxsel[k] <= wr_data[$bits(muxsel_t)-1:0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/front_panel_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module front_panel_ctrl (
	input  wire                           clk,
	input  wire                           rst_n,

	// Host bus
	input  wire                           wr_en,
	input  mgmt_pkg::reg_addr_t           wr_addr,
	input  mgmt_pkg::reg_data_t           wr_data,
	input  wire                           rd_en,
	input  mgmt_pkg::reg_addr_t           rd_addr,
	output mgmt_pkg::reg_data_t           rd_data,

	// Status for the LED indicators
	input  wire [mgmt_pkg::NUM_TRIG-1:0]  trig_in_led,
	input  wire [mgmt_pkg::NUM_TRIG-1:0]  trig_out_led,
	input  wire [mgmt_pkg::NUM_RELAY-1:0] relay_state,

	// SPI shifter
	output logic                          front_shift_en,
	output mgmt_pkg::reg_data_t           front_shift_data,
	input  wire                           front_shift_done,
	input  mgmt_pkg::reg_data_t           front_rx_data,
	output logic                          front_cs_n
);

	import mgmt_pkg::*;

	// First relay switched output channel
	localparam int RELAY_FIRST = NUM_TRIG - NUM_RELAY;

	logic [2*NUM_TRIG-1:0] led_state;
	logic                  shift_req;
	reg_data_t             shift_byte;
	logic                  busy;

	////////////////////////////////////////
	// LED status word

	always_comb begin
		// Low half shows the outputs
		led_state[NUM_TRIG-1:0] = trig_out_led;
		// Relay in input mode, keep its output LED dark
		for (int k = 0; k < NUM_RELAY; k++) begin
			if (relay_state[k])
				led_state[RELAY_FIRST+k] = 1'b0;
		end
		// High half shows the inputs in reversed order
		for (int i = 0; i < NUM_TRIG; i++)
			led_state[NUM_TRIG+i] = trig_in_led[NUM_TRIG-1-i];
	end

	////////////////////////////////////////
	// Write decode

	// Raw byte or one of the three LED bytes
	always_comb begin
		shift_req  = 1'b0;
		shift_byte = wr_data;
		if (wr_en) begin
			case (wr_addr)
				REG_FRONT_DATA: shift_req = 1'b1;
				REG_FRONT_LED_0: begin
					shift_req  = 1'b1;
					shift_byte = led_state[7:0];
				end
				REG_FRONT_LED_1: begin
					shift_req  = 1'b1;
					shift_byte = led_state[15:8];
				end
				REG_FRONT_LED_2: begin
					shift_req  = 1'b1;
					shift_byte = led_state[23:16];
				end
				default: shift_req = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			front_shift_en   <= 1'b0;
			front_shift_data <= '0;
			front_cs_n       <= 1'b1;
			busy             <= 1'b0;
		end
		else begin
			// One cycle request, data held until the next one
			front_shift_en <= shift_req;
			if (shift_req)
				front_shift_data <= shift_byte;
			if (wr_en && wr_addr == REG_FRONT_CTRL)
				front_cs_n <= wr_data[0];
			// Done has priority over a new request
			if (front_shift_done)
				busy <= 1'b0;
			else if (shift_req)
				busy <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Read decode

	// Zero whenever the address is not ours
	always_ff @(posedge clk) begin
		rd_data <= '0;
		if (rd_en) begin
			case (rd_addr)
				REG_FRONT_STAT: rd_data <= {7'b0, busy};
				REG_FRONT_DATA: rd_data <= front_rx_data;
				default:        rd_data <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/drp_lane_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module drp_lane_ctrl #(
	// Start of this lane's 32 byte register window
	parameter mgmt_pkg::reg_addr_t LANE_BASE = mgmt_pkg::REG_LANE0_BASE
) (
	input  wire                 clk,
	input  wire                 rst_n,

	// Host bus
	input  wire                 wr_en,
	input  mgmt_pkg::reg_addr_t wr_addr,
	input  mgmt_pkg::reg_data_t wr_data,
	input  wire                 rd_en,
	input  mgmt_pkg::reg_addr_t rd_addr,
	output mgmt_pkg::reg_data_t rd_data,

	// Transceiver DRP port
	output logic                drp_en,
	output logic                drp_we,
	output mgmt_pkg::drp_addr_t drp_addr,
	output mgmt_pkg::drp_data_t drp_wdata,
	input  mgmt_pkg::drp_data_t drp_rdata,
	input  wire                 drp_done,
	input  wire                 rx_rstdone
);

	import mgmt_pkg::*;

	// Absolute addresses of the lane registers
	localparam reg_addr_t ADDR_WD   = LANE_BASE + reg_addr_t'(DRP_OFF_WD);
	localparam reg_addr_t ADDR_WD_1 = LANE_BASE + reg_addr_t'(DRP_OFF_WD_1);
	localparam reg_addr_t ADDR_AD   = LANE_BASE + reg_addr_t'(DRP_OFF_AD);
	localparam reg_addr_t ADDR_AD_1 = LANE_BASE + reg_addr_t'(DRP_OFF_AD_1);
	localparam reg_addr_t ADDR_RD   = LANE_BASE + reg_addr_t'(DRP_OFF_RD);
	localparam reg_addr_t ADDR_RD_1 = LANE_BASE + reg_addr_t'(DRP_OFF_RD_1);
	localparam reg_addr_t ADDR_STAT = LANE_BASE + reg_addr_t'(DRP_OFF_STAT);

	logic start;
	logic busy;

	// Writing the high address byte launches the transaction
	assign start = wr_en && (wr_addr == ADDR_AD_1);

	////////////////////////////////////////
	// Staging and start

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			drp_en    <= 1'b0;
			drp_we    <= 1'b0;
			drp_addr  <= '0;
			drp_wdata <= '0;
			busy      <= 1'b0;
		end
		else begin
			drp_en <= start;
			if (wr_en) begin
				case (wr_addr)
					ADDR_WD:   drp_wdata[7:0]  <= wr_data;
					ADDR_WD_1: drp_wdata[15:8] <= wr_data;
					ADDR_AD:   drp_addr[7:0]   <= wr_data;
					ADDR_AD_1: begin
						// Bit 7 is the write flag, bit 0 the address MSB
						drp_addr[8] <= wr_data[0];
						drp_we      <= wr_data[7];
					end
					default: ;
				endcase
			end
			// Done has priority over a new start
			if (drp_done)
				busy <= 1'b0;
			else if (start)
				busy <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Read decode

	// Zero outside this window so the top can OR lanes together
	always_ff @(posedge clk) begin
		rd_data <= '0;
		if (rd_en) begin
			case (rd_addr)
				ADDR_RD:   rd_data <= drp_rdata[7:0];
				ADDR_RD_1: rd_data <= drp_rdata[15:8];
				ADDR_STAT: rd_data <= {6'b0, rx_rstdone, busy};
				default:   rd_data <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/mgmt_regs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mgmt_regs_top (
	input  wire                                        clk,
	input  wire                                        rst_n,

	// Host register bus
	input  wire                                        rd_en,
	input  mgmt_pkg::reg_addr_t                        rd_addr,
	output logic                                       rd_valid,
	output mgmt_pkg::reg_data_t                        rd_data,
	input  wire                                        wr_en,
	input  mgmt_pkg::reg_addr_t                        wr_addr,
	input  mgmt_pkg::reg_data_t                        wr_data,

	// Crossbar selectors and LED status
	output mgmt_pkg::muxsel_t [mgmt_pkg::NUM_TRIG-1:0] muxsel,
	input  wire [mgmt_pkg::NUM_TRIG-1:0]               trig_in_led,
	input  wire [mgmt_pkg::NUM_TRIG-1:0]               trig_out_led,
	input  wire [mgmt_pkg::NUM_RELAY-1:0]              relay_state,

	// Front panel SPI
	output logic                                       front_shift_en,
	output mgmt_pkg::reg_data_t                        front_shift_data,
	input  wire                                        front_shift_done,
	input  mgmt_pkg::reg_data_t                        front_rx_data,
	output logic                                       front_cs_n,

	// Lane 0 DRP
	output logic                                       lane0_drp_en,
	output logic                                       lane0_drp_we,
	output mgmt_pkg::drp_addr_t                        lane0_drp_addr,
	output mgmt_pkg::drp_data_t                        lane0_drp_wdata,
	input  mgmt_pkg::drp_data_t                        lane0_drp_rdata,
	input  wire                                        lane0_drp_done,
	input  wire                                        lane0_rx_rstdone,

	// Lane 1 DRP
	output logic                                       lane1_drp_en,
	output logic                                       lane1_drp_we,
	output mgmt_pkg::drp_addr_t                        lane1_drp_addr,
	output mgmt_pkg::drp_data_t                        lane1_drp_wdata,
	input  mgmt_pkg::drp_data_t                        lane1_drp_rdata,
	input  wire                                        lane1_drp_done,
	input  wire                                        lane1_rx_rstdone
);

	import mgmt_pkg::*;

	// Per block read bytes, zero unless the block owns rd_addr
	reg_data_t front_rd_data;
	reg_data_t lane0_rd_data;
	reg_data_t lane1_rd_data;

	////////////////////////////////////////
	// Read response

	// Every read completes one cycle after the strobe
	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_en;
	end

	// Blocks decode disjoint ranges so a plain OR merges them
	assign rd_data = front_rd_data | lane0_rd_data | lane1_rd_data;

	////////////////////////////////////////
	// Register blocks

	// Selectors are write only
	trig_mux_select mux_sel (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.muxsel  (muxsel)
	);

	front_panel_ctrl front (
		.clk              (clk),
		.rst_n            (rst_n),
		.wr_en            (wr_en),
		.wr_addr          (wr_addr),
		.wr_data          (wr_data),
		.rd_en            (rd_en),
		.rd_addr          (rd_addr),
		.rd_data          (front_rd_data),
		.trig_in_led      (trig_in_led),
		.trig_out_led     (trig_out_led),
		.relay_state      (relay_state),
		.front_shift_en   (front_shift_en),
		.front_shift_data (front_shift_data),
		.front_shift_done (front_shift_done),
		.front_rx_data    (front_rx_data),
		.front_cs_n       (front_cs_n)
	);

	// Same lane logic, placed at two windows
	drp_lane_ctrl #(
		.LANE_BASE (REG_LANE0_BASE)
	) lane0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.rd_data    (lane0_rd_data),
		.drp_en     (lane0_drp_en),
		.drp_we     (lane0_drp_we),
		.drp_addr   (lane0_drp_addr),
		.drp_wdata  (lane0_drp_wdata),
		.drp_rdata  (lane0_drp_rdata),
		.drp_done   (lane0_drp_done),
		.rx_rstdone (lane0_rx_rstdone)
	);

	drp_lane_ctrl #(
		.LANE_BASE (REG_LANE1_BASE)
	) lane1 (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.rd_data    (lane1_rd_data),
		.drp_en     (lane1_drp_en),
		.drp_we     (lane1_drp_we),
		.drp_addr   (lane1_drp_addr),
		.drp_wdata  (lane1_drp_wdata),
		.drp_rdata  (lane1_drp_rdata),
		.drp_done   (lane1_drp_done),
		.rx_rstdone (lane1_rx_rstdone)
	);

endmodule

`default_nettype wire

// ==== verification/mgmt_tb_tasks.svh ====
`ifndef MGMT_TB_TASKS_SVH
`define MGMT_TB_TASKS_SVH

////////////////////////////////////////
// Host bus access

// One cycle write strobe, driven between falling edges
task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
	@(negedge clk);
	wr_en   = 1'b1;
	wr_addr = addr;
	wr_data = data;
	@(negedge clk);
	wr_en   = 1'b0;
endtask

// Strobe rd_en once, then take the byte from the rd_valid cycle
task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
	@(negedge clk);
	rd_en   = 1'b1;
	rd_addr = addr;
	@(negedge clk);
	rd_en   = 1'b0;
	// Response belongs to the cycle right after the strobe
	check_value("rd_valid", 32'(rd_valid), 1);
	data = rd_data;
	@(negedge clk);
	// Valid lasts that one cycle only
	check_value("rd_valid", 32'(rd_valid), 0);
endtask

////////////////////////////////////////
// Compare and count

task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
	checks++;
	if (got !== expected) begin
		errors++;
		$display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
	end
endtask

////////////////////////////////////////
// LED status reference

// Outputs low, relay channels dark when set, inputs mirrored on top
function automatic reg_data_t led_byte(input int idx, input logic [11:0] in,
		input logic [11:0] out, input logic [3:0] relay);
	logic [23:0] word;
	word[11:0] = out;
	for (int k = 0; k < 4; k++) begin
		if (relay[k])
			word[8+k] = 1'b0;
	end
	for (int i = 0; i < 12; i++)
		word[12+i] = in[11-i];
	return word[idx*8 +: 8];
endfunction

`endif

// ==== verification/mgmt_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mgmt_tb;

	import mgmt_pkg::*;

	// Clock, reset and host bus
	logic      clk;
	logic      rst_n;
	logic      rd_en;
	reg_addr_t rd_addr;
	logic      rd_valid;
	reg_data_t rd_data;
	logic      wr_en;
	reg_addr_t wr_addr;
	reg_data_t wr_data;

	// Crossbar and LED status
	muxsel_t [NUM_TRIG-1:0] muxsel;
	logic [NUM_TRIG-1:0]    trig_in_led;
	logic [NUM_TRIG-1:0]    trig_out_led;
	logic [NUM_RELAY-1:0]   relay_state;

	// Front panel SPI
	logic      front_shift_en;
	reg_data_t front_shift_data;
	logic      front_shift_done;
	reg_data_t front_rx_data;
	logic      front_cs_n;

	// DRP lanes
	logic      lane0_drp_en;
	logic      lane0_drp_we;
	drp_addr_t lane0_drp_addr;
	drp_data_t lane0_drp_wdata;
	drp_data_t lane0_drp_rdata;
	logic      lane0_drp_done;
	logic      lane0_rx_rstdone;
	logic      lane1_drp_en;
	logic      lane1_drp_we;
	drp_addr_t lane1_drp_addr;
	drp_data_t lane1_drp_wdata;
	drp_data_t lane1_drp_rdata;
	logic      lane1_drp_done;
	logic      lane1_rx_rstdone;

	// Bookkeeping
	int        seed;
	int        resp_seed;
	int        cyc;
	int        errors;
	int        checks;
	int        tests;
	int        spi_due[$];
	int        lane0_due[$];
	int        lane1_due[$];
	reg_data_t shift_q[$];
	int        lane0_starts;
	int        lane1_starts;

	`include "mgmt_tb_tasks.svh"

	mgmt_regs_top dut (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	////////////////////////////////////////
	// Responders and monitor

	// Done falls 2 to 9 cycles after each request, in request order
	function automatic int next_due(input int last);
		int due;
		due = cyc + 2 + int'({$random(resp_seed)} % 32'd8);
		if (due <= last)
			due = last + 1;
		return due;
	endfunction

	initial begin
		resp_seed        = 32'h5ea;
		cyc              = 0;
		front_shift_done = 1'b0;
		lane0_drp_done   = 1'b0;
		lane1_drp_done   = 1'b0;
		forever begin
			@(negedge clk);
			cyc++;
			front_shift_done = 1'b0;
			lane0_drp_done   = 1'b0;
			lane1_drp_done   = 1'b0;
			if (spi_due.size() > 0 && spi_due[0] == cyc) begin
				front_shift_done = 1'b1;
				void'(spi_due.pop_front());
			end
			if (lane0_due.size() > 0 && lane0_due[0] == cyc) begin
				lane0_drp_done = 1'b1;
				void'(lane0_due.pop_front());
			end
			if (lane1_due.size() > 0 && lane1_due[0] == cyc) begin
				lane1_drp_done = 1'b1;
				void'(lane1_due.pop_front());
			end
			// Queue new requests behind any pending ones
			if (front_shift_en)
				spi_due.push_back(next_due(spi_due.size() > 0 ? spi_due[$] : 0));
			if (lane0_drp_en)
				lane0_due.push_back(next_due(lane0_due.size() > 0 ? lane0_due[$] : 0));
			if (lane1_drp_en)
				lane1_due.push_back(next_due(lane1_due.size() > 0 ? lane1_due[$] : 0));
		end
	end

	// Shift bytes and start pulses as the DUT issues them
	initial begin
		lane0_starts = 0;
		lane1_starts = 0;
		forever begin
			@(negedge clk);
			if (front_shift_en)
				shift_q.push_back(front_shift_data);
			if (lane0_drp_en)
				lane0_starts++;
			if (lane1_drp_en)
				lane1_starts++;
		end
	end

	////////////////////////////////////////
	// Test helpers

	// Idle means no pending request and no done pulse in flight
	task automatic wait_idle();
		int waited;
		waited = 0;
		@(posedge clk);
		while ((spi_due.size() != 0 || lane0_due.size() != 0 || lane1_due.size() != 0 ||
				front_shift_done || lane0_drp_done || lane1_drp_done) && waited < 40) begin
			@(posedge clk);
			waited++;
		end
		if (waited >= 40) begin
			$display("Timed out waiting for the SPI and DRP responders to go idle");
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int errs_at_start);
		tests++;
		$display("Test %0d %-12s %s", tests, name,
			(errors == errs_at_start) ? "passed" : "failed");
	endtask

	task automatic drive_lane_status(input int lane, input drp_data_t rdata,
			input logic rstdone);
		if (lane == 0) begin
			lane0_drp_rdata  = rdata;
			lane0_rx_rstdone = rstdone;
		end
		else begin
			lane1_drp_rdata  = rdata;
			lane1_rx_rstdone = rstdone;
		end
	endtask

	////////////////////////////////////////
	// Tests

	task automatic test_reset_state();
		int        errs;
		reg_data_t val;
		errs = errors;
		@(negedge clk);
		check_value("rd_valid", 32'(rd_valid), 0);
		check_value("front_shift_en", 32'(front_shift_en), 0);
		check_value("lane0_drp_en", 32'(lane0_drp_en), 0);
		check_value("lane1_drp_en", 32'(lane1_drp_en), 0);
		check_value("front_cs_n", 32'(front_cs_n), 1);
		for (int k = 0; k < NUM_TRIG; k++)
			check_value($sformatf("muxsel[%0d]", k), 32'(muxsel[k]), 0);
		// Nothing decodes 0x0010
		reg_read(16'h0010, val);
		check_value("rd_data", 32'(val), 0);
		end_test("reset", errs);
	endtask

	task automatic test_mux_select();
		int        errs;
		muxsel_t   vals [NUM_TRIG];
		reg_data_t wr_byte;
		errs = errors;
		for (int k = 0; k < NUM_TRIG; k++) begin
			wr_byte = reg_data_t'($random(seed));
			vals[k] = wr_byte[3:0];
			reg_write(reg_addr_t'(REG_MUXSEL_BASE + k), wr_byte);
		end
		for (int k = 0; k < NUM_TRIG; k++)
			check_value($sformatf("muxsel[%0d]", k), 32'(muxsel[k]), 32'(vals[k]));
		// One past the last channel
		reg_write(16'h00fc, reg_data_t'($random(seed)));
		for (int k = 0; k < NUM_TRIG; k++)
			check_value($sformatf("muxsel[%0d]", k), 32'(muxsel[k]), 32'(vals[k]));
		end_test("mux_select", errs);
	endtask

	task automatic test_led_push();
		int errs;
		int base;
		int waited;
		errs = errors;
		wait_idle();
		base = shift_q.size();
		@(negedge clk);
		trig_in_led  = NUM_TRIG'($random(seed));
		trig_out_led = NUM_TRIG'($random(seed));
		relay_state  = NUM_RELAY'($random(seed));
		// Data byte is ignored for the LED registers
		reg_write(REG_FRONT_LED_0, reg_data_t'($random(seed)));
		reg_write(REG_FRONT_LED_1, reg_data_t'($random(seed)));
		reg_write(REG_FRONT_LED_2, reg_data_t'($random(seed)));
		waited = 0;
		while (shift_q.size() < base + 3 && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (shift_q.size() < base + 3) begin
			$display("Timed out waiting for three LED shift requests");
			errors++;
		end
		else begin
			for (int i = 0; i < 3; i++)
				check_value($sformatf("front_shift_data[%0d]", i), 32'(shift_q[base+i]),
					32'(led_byte(i, trig_in_led, trig_out_led, relay_state)));
		end
		end_test("led_push", errs);
	endtask

	task automatic test_front_spi();
		int        errs;
		int        base;
		reg_data_t tx_byte;
		reg_data_t rx_byte;
		reg_data_t val;
		errs    = errors;
		tx_byte = reg_data_t'($random(seed));
		rx_byte = reg_data_t'($random(seed));
		wait_idle();
		base = shift_q.size();
		reg_write(REG_FRONT_DATA, tx_byte);
		// Done is at least two cycles out, so busy still shows
		reg_read(REG_FRONT_STAT, val);
		check_value("front_stat", 32'(val), 1);
		if (shift_q.size() != base + 1) begin
			$display("Expected one SPI request after the data write, saw %0d",
				shift_q.size() - base);
			errors++;
		end
		else begin
			check_value("front_shift_data", 32'(shift_q[base]), 32'(tx_byte));
		end
		wait_idle();
		reg_read(REG_FRONT_STAT, val);
		check_value("front_stat", 32'(val), 0);
		@(negedge clk);
		front_rx_data = rx_byte;
		reg_read(REG_FRONT_DATA, val);
		check_value("front_rx_readback", 32'(val), 32'(rx_byte));
		reg_write(REG_FRONT_CTRL, 8'h00);
		check_value("front_cs_n", 32'(front_cs_n), 0);
		reg_write(REG_FRONT_CTRL, 8'h01);
		check_value("front_cs_n", 32'(front_cs_n), 1);
		end_test("front_spi", errs);
	endtask

	task automatic drp_lane_test(input int lane);
		int        errs;
		int        starts0;
		int        starts1;
		reg_addr_t base;
		reg_data_t wd_lo;
		reg_data_t wd_hi;
		reg_data_t ad_lo;
		reg_data_t ad_hi;
		drp_data_t rdata;
		logic      rstdone;
		reg_data_t val;
		string     pfx;
		errs    = errors;
		base    = (lane == 0) ? REG_LANE0_BASE : REG_LANE1_BASE;
		pfx     = $sformatf("lane%0d_", lane);
		wd_lo   = reg_data_t'($random(seed));
		wd_hi   = reg_data_t'($random(seed));
		ad_lo   = reg_data_t'($random(seed));
		ad_hi   = reg_data_t'($random(seed));
		rdata   = drp_data_t'($random(seed));
		rstdone = 1'($random(seed));
		wait_idle();
		starts0 = lane0_starts;
		starts1 = lane1_starts;
		@(negedge clk);
		drive_lane_status(lane, rdata, rstdone);
		reg_write(base + reg_addr_t'(DRP_OFF_WD), wd_lo);
		reg_write(base + reg_addr_t'(DRP_OFF_WD_1), wd_hi);
		reg_write(base + reg_addr_t'(DRP_OFF_AD), ad_lo);
		// High address byte carries the write flag and starts the access
		reg_write(base + reg_addr_t'(DRP_OFF_AD_1), ad_hi);
		check_value({pfx, "drp_addr"},
			32'((lane != 0) ? lane1_drp_addr : lane0_drp_addr), 32'({ad_hi[0], ad_lo}));
		check_value({pfx, "drp_wdata"},
			32'((lane != 0) ? lane1_drp_wdata : lane0_drp_wdata), 32'({wd_hi, wd_lo}));
		check_value({pfx, "drp_we"},
			32'((lane != 0) ? lane1_drp_we : lane0_drp_we), 32'(ad_hi[7]));
		reg_read(base + reg_addr_t'(DRP_OFF_STAT), val);
		check_value({pfx, "stat"}, 32'(val), 32'({6'b0, rstdone, 1'b1}));
		wait_idle();
		check_value("lane0_drp_en pulses", lane0_starts - starts0, (lane == 0) ? 1 : 0);
		check_value("lane1_drp_en pulses", lane1_starts - starts1, (lane == 1) ? 1 : 0);
		reg_read(base + reg_addr_t'(DRP_OFF_STAT), val);
		check_value({pfx, "stat"}, 32'(val), 32'({6'b0, rstdone, 1'b0}));
		reg_read(base + reg_addr_t'(DRP_OFF_RD), val);
		check_value({pfx, "rd_lo"}, 32'(val), 32'(rdata[7:0]));
		reg_read(base + reg_addr_t'(DRP_OFF_RD_1), val);
		check_value({pfx, "rd_hi"}, 32'(val), 32'(rdata[15:8]));
		// Flip reset done and see it in the status byte
		@(negedge clk);
		drive_lane_status(lane, rdata, !rstdone);
		reg_read(base + reg_addr_t'(DRP_OFF_STAT), val);
		check_value({pfx, "stat"}, 32'(val), 32'({6'b0, !rstdone, 1'b0}));
		end_test({pfx, "drp"}, errs);
	endtask

	////////////////////////////////////////
	// Main sequence

	initial begin
		seed             = 32'h5ea;
		errors           = 0;
		checks           = 0;
		tests            = 0;
		rst_n            = 1'b0;
		rd_en            = 1'b0;
		rd_addr          = '0;
		wr_en            = 1'b0;
		wr_addr          = '0;
		wr_data          = '0;
		trig_in_led      = '0;
		trig_out_led     = '0;
		relay_state      = '0;
		front_rx_data    = '0;
		lane0_drp_rdata  = '0;
		lane0_rx_rstdone = 1'b0;
		lane1_drp_rdata  = '0;
		lane1_rx_rstdone = 1'b0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		test_reset_state();
		test_mux_select();
		test_led_push();
		test_front_spi();
		drp_lane_test(0);
		drp_lane_test(1);

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verification
logic/mgmt_pkg.sv
logic/trig_mux_select.sv
logic/front_panel_ctrl.sv
logic/drp_lane_ctrl.sv
logic/mgmt_regs_top.sv
verification/mgmt_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module mgmt_tb -f build.f -o mgmt_sim > sim.log 2>&1 &&
	./obj_dir/mgmt_sim >> sim.log 2>&1 ||
	{ echo "Build or simulation did not complete, see sim.log"; exit 1; }
grep -q "Errors found" sim.log &&
	{ echo "Simulation reported failures, see sim.log"; exit 1; } ||
	{ echo "Simulation passed"; exit 0; }
